//--- lc3b_types.sv
package lc3b_types;

    // Line geometry. A 16-bit byte address splits into tag, index and offset.
    localparam int LINE_OFFSET_BITS = 4;       // Sixteen bytes per line.
    localparam int INDEX_BITS       = 3;
    localparam int NUM_LINES        = 8;       // Matches 2**INDEX_BITS.
    localparam int TAG_BITS         = 16 - INDEX_BITS - LINE_OFFSET_BITS;

    typedef logic [15:0]  lc3b_word;           // Byte address.
    typedef logic [127:0] lc3b_cacheline;      // Eight 16-bit words.

    typedef logic [TAG_BITS-1:0]   lc3b_tag;
    typedef logic [INDEX_BITS-1:0] lc3b_index;

endpackage : lc3b_types

//--- mem_if.sv
`timescale 1ns/1ps

interface mem_if
    import lc3b_types::*;
();

    logic          read;       // Level, held until resp.
    logic          write;      // Level, never high together with read.
    lc3b_word      address;
    lc3b_cacheline wdata;
    logic          resp;       // One-cycle pulse that ends the request.
    lc3b_cacheline rdata;      // Valid in the resp cycle of a read.

    modport requester (
        output read,
        output write,
        output address,
        output wdata,
        input  resp,
        input  rdata
    );

    modport responder (
        input  read,
        input  write,
        input  address,
        input  wdata,
        output resp,
        output rdata
    );

endinterface : mem_if

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import lc3b_types::*;
(
    input  logic          clk,
    input  logic          rst_n_i,

    input  logic          d_read_i,
    input  logic          d_write_i,
    input  lc3b_word      d_address_i,
    input  lc3b_cacheline d_wdata_i,
    output logic          d_resp_o,
    output lc3b_cacheline d_rdata_o,

    input  logic          i_read_i,
    input  lc3b_word      i_address_i,
    output logic          i_resp_o,
    output lc3b_cacheline i_rdata_o,

    mem_if.requester      down_bus
);

    logic busy_q;       // A grant is active and waits for the cache's resp.
    logic grant_d_q;    // High when the data port owns the grant.
    logic d_req;

    assign d_req = d_read_i | d_write_i;

    // The data port has fixed priority. Once granted, a port keeps the channel
    // until its transaction ends, so a request is never cut in the middle.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            grant_d_q <= 1'b0;
        end else if (!busy_q) begin
            busy_q    <= d_req | i_read_i;
            grant_d_q <= d_req;                // Instruction port only if data is quiet.
        end else if (down_bus.resp) begin
            busy_q    <= 1'b0;                 // Back to idle for one cycle.
        end
    end

    // Present the granted port on the merged channel.
    assign down_bus.read    = busy_q & (grant_d_q ? d_read_i : i_read_i);
    assign down_bus.write   = busy_q & grant_d_q & d_write_i;  // Instruction side never writes.
    assign down_bus.address = grant_d_q ? d_address_i : i_address_i;
    assign down_bus.wdata   = d_wdata_i;

    // Resp goes straight back to the owner in the same cycle.
    assign d_resp_o  = busy_q & grant_d_q & down_bus.resp;
    assign i_resp_o  = busy_q & ~grant_d_q & down_bus.resp;
    assign d_rdata_o = down_bus.rdata;
    assign i_rdata_o = down_bus.rdata;

endmodule : mem_arbiter

//--- l2_cache.sv
`timescale 1ns/1ps

module l2_cache
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    mem_if.responder up_bus,
    mem_if.requester down_bus
);

    // Line storage.
    lc3b_cacheline        data_q [NUM_LINES];
    lc3b_tag              tag_q  [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;

    // Controller. Compare is the state where both flags are low.
    logic wb_q;          // Writing the dirty victim to down_bus.
    logic fill_q;        // Reading the missing line from down_bus.
    logic resp_q;
    lc3b_cacheline rdata_q;

    lc3b_tag   req_tag;
    lc3b_index req_index;
    logic      compare;
    logic      req_valid;
    logic      hit;
    logic      victim_dirty;
    logic      do_store;
    logic      do_read_hit;
    logic      fill_done;

    assign req_tag   = up_bus.address[LINE_OFFSET_BITS+INDEX_BITS +: TAG_BITS];
    assign req_index = up_bus.address[LINE_OFFSET_BITS +: INDEX_BITS];

    assign compare = ~wb_q & ~fill_q;

    // A request seen in the resp cycle is the one just answered.
    assign req_valid    = compare & (up_bus.read | up_bus.write) & ~resp_q;
    assign hit          = valid_q[req_index] & (tag_q[req_index] == req_tag);
    assign victim_dirty = valid_q[req_index] & dirty_q[req_index];

    // Whole-line writes install directly once the slot is hit or clean.
    assign do_store    = req_valid & up_bus.write & (hit | ~victim_dirty);
    assign do_read_hit = req_valid & up_bus.read & hit;
    assign fill_done   = fill_q & down_bus.resp;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_q    <= 1'b0;
            fill_q  <= 1'b0;
            resp_q  <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            resp_q <= do_store | do_read_hit;      // Hit answers one cycle later.
            if (req_valid && !hit && victim_dirty) begin
                wb_q <= 1'b1;                      // Evict before reuse of the slot.
            end else if (req_valid && up_bus.read && !hit) begin
                fill_q <= 1'b1;
            end
            if (wb_q && down_bus.resp) begin
                wb_q               <= 1'b0;
                dirty_q[req_index] <= 1'b0;        // Compare again with a clean slot.
            end
            if (fill_done) begin
                fill_q             <= 1'b0;
                valid_q[req_index] <= 1'b1;
                dirty_q[req_index] <= 1'b0;        // Next compare is a hit.
            end
            if (do_store) begin
                valid_q[req_index] <= 1'b1;
                dirty_q[req_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_store) begin
            data_q[req_index] <= up_bus.wdata;
            tag_q[req_index]  <= req_tag;
        end
        if (fill_done) begin
            data_q[req_index] <= down_bus.rdata;
            tag_q[req_index]  <= req_tag;
        end
        if (do_read_hit) begin
            rdata_q <= data_q[req_index];
        end
    end

    assign up_bus.resp  = resp_q;
    assign up_bus.rdata = rdata_q;

    // The write-back goes to the old tag's line address, the fill to the new one.
    assign down_bus.write   = wb_q;
    assign down_bus.read    = fill_q;
    assign down_bus.address = wb_q ? {tag_q[req_index], req_index, {LINE_OFFSET_BITS{1'b0}}}
                                   : {req_tag, req_index, {LINE_OFFSET_BITS{1'b0}}};
    assign down_bus.wdata   = data_q[req_index];

endmodule : l2_cache

//--- victim_buffer.sv
`timescale 1ns/1ps

module victim_buffer
    import lc3b_types::*;
(
    input  logic          clk,
    input  logic          rst_n_i,
    mem_if.responder      up_bus,

    output logic          pmem_read_o,
    output logic          pmem_write_o,
    output lc3b_word      pmem_address_o,
    output lc3b_cacheline pmem_wdata_o,
    input  logic          pmem_resp_i,
    input  lc3b_cacheline pmem_rdata_i
);

    logic          valid_q;        // Buffer holds a line not yet in memory.
    logic          flush_q;        // Writing the held line to pmem.
    logic          fwd_q;          // Read forwarded to pmem.
    logic          resp_q;
    lc3b_tag       held_tag_q;
    lc3b_index     held_index_q;
    lc3b_cacheline held_line_q;
    lc3b_cacheline rdata_q;

    lc3b_tag   req_tag;
    lc3b_index req_index;
    logic      idle;
    logic      req_valid;
    logic      held_match;
    logic      accept_evict;
    logic      serve_read;

    assign req_tag   = up_bus.address[LINE_OFFSET_BITS+INDEX_BITS +: TAG_BITS];
    assign req_index = up_bus.address[LINE_OFFSET_BITS +: INDEX_BITS];

    assign idle         = ~flush_q & ~fwd_q;
    assign req_valid    = idle & (up_bus.read | up_bus.write) & ~resp_q;
    assign held_match   = valid_q & (held_tag_q == req_tag) & (held_index_q == req_index);
    assign accept_evict = req_valid & up_bus.write & ~valid_q;
    assign serve_read   = req_valid & up_bus.read & held_match;  // Line stays valid.

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            flush_q <= 1'b0;
            fwd_q   <= 1'b0;
            resp_q  <= 1'b0;
        end else begin
            resp_q <= accept_evict | serve_read;
            if (accept_evict) begin
                valid_q <= 1'b1;
            end
            if (req_valid && up_bus.write && valid_q) begin
                flush_q <= 1'b1;                   // Make room for the new victim.
            end else if (req_valid && up_bus.read && !held_match) begin
                fwd_q <= 1'b1;
            end else if (idle && valid_q && !up_bus.read && !up_bus.write) begin
                flush_q <= 1'b1;                   // Drain in a quiet cycle.
            end
            if (flush_q && pmem_resp_i) begin
                flush_q <= 1'b0;
                valid_q <= 1'b0;
            end
            if (fwd_q && pmem_resp_i) begin
                fwd_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_evict) begin
            held_tag_q   <= req_tag;
            held_index_q <= req_index;
            held_line_q  <= up_bus.wdata;
        end
        if (serve_read) begin
            rdata_q <= held_line_q;
        end
    end

    assign pmem_read_o    = fwd_q;
    assign pmem_write_o   = flush_q;
    assign pmem_address_o = flush_q ? {held_tag_q, held_index_q, {LINE_OFFSET_BITS{1'b0}}}
                                    : up_bus.address;
    assign pmem_wdata_o   = held_line_q;

    // A forwarded read finishes on the pmem resp itself.
    assign up_bus.resp  = resp_q | (fwd_q & pmem_resp_i);
    assign up_bus.rdata = fwd_q ? pmem_rdata_i : rdata_q;

endmodule : victim_buffer

//--- mem_hierarchy.sv
`timescale 1ns/1ps

module mem_hierarchy
    import lc3b_types::*;
(
    input  logic          clk,
    input  logic          rst_n_i,

    // Data port, reads and writes whole lines.
    input  logic          d_read_i,
    input  logic          d_write_i,
    input  lc3b_word      d_address_i,
    input  lc3b_cacheline d_wdata_i,
    output logic          d_resp_o,
    output lc3b_cacheline d_rdata_o,

    // Instruction port, read only.
    input  logic          i_read_i,
    input  lc3b_word      i_address_i,
    output logic          i_resp_o,
    output lc3b_cacheline i_rdata_o,

    // Physical memory.
    output logic          pmem_read_o,
    output logic          pmem_write_o,
    output lc3b_word      pmem_address_o,
    output lc3b_cacheline pmem_wdata_o,
    input  logic          pmem_resp_i,
    input  lc3b_cacheline pmem_rdata_i
);

    mem_if arb_bus ();     // Arbiter to cache.
    mem_if vb_bus ();      // Cache to victim buffer.

    mem_arbiter u_mem_arbiter (
        .clk, .rst_n_i,
        .d_read_i, .d_write_i, .d_address_i, .d_wdata_i, .d_resp_o, .d_rdata_o,
        .i_read_i, .i_address_i, .i_resp_o, .i_rdata_o,
        .down_bus (arb_bus.requester)
    );

    l2_cache u_l2_cache (
        .clk, .rst_n_i,
        .up_bus   (arb_bus.responder),
        .down_bus (vb_bus.requester)
    );

    victim_buffer u_victim_buffer (
        .clk, .rst_n_i,
        .up_bus (vb_bus.responder),
        .pmem_read_o, .pmem_write_o, .pmem_address_o, .pmem_wdata_o,
        .pmem_resp_i, .pmem_rdata_i
    );

endmodule : mem_hierarchy

//--- mem_hierarchy_asserts.sv
`timescale 1ns/1ps

module mem_hierarchy_asserts
    import lc3b_types::*;
(
    input logic     clk,
    input logic     rst_n_i,
    input logic     d_read_i,
    input logic     d_write_i,
    input logic     d_resp_o,
    input logic     i_read_i,
    input logic     i_resp_o,
    input logic     pmem_read_o,
    input logic     pmem_write_o,
    input lc3b_word pmem_address_o,
    input logic     pmem_resp_i
);

    int fail_count = 0;     // Failed assertions so far, summed into the closing line.

    pmem_one_op: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(pmem_read_o && pmem_write_o))
        else begin
            $error("pmem read and write are high together");
            fail_count++;
        end

    // A waiting request keeps its address until memory answers.
    pmem_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (pmem_read_o || pmem_write_o) && !pmem_resp_i |=> $stable(pmem_address_o))
        else begin
            $error("pmem address changed while the request waits");
            fail_count++;
        end

    d_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        d_resp_o |-> (d_read_i || d_write_i))
        else begin
            $error("d_resp_o without a data port request");
            fail_count++;
        end

    i_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        i_resp_o |-> i_read_i)
        else begin
            $error("i_resp_o without an instruction port request");
            fail_count++;
        end

    pmem_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        pmem_resp_i |-> (pmem_read_o || pmem_write_o))
        else begin
            $error("pmem_resp_i without a pmem request");
            fail_count++;
        end

endmodule : mem_hierarchy_asserts

bind mem_hierarchy mem_hierarchy_asserts u_asserts (.*);

//--- tb_mem_hierarchy.sv
`timescale 1ns/1ps

module tb_mem_hierarchy
    import lc3b_types::*;
();

    localparam int TIMEOUT_CYCLES = 200;        // Worst miss with a full buffer fits easily.

    logic          clk;
    logic          rst_n_i;
    logic          d_read_i, d_write_i, d_resp_o, i_read_i, i_resp_o;
    lc3b_word      d_address_i, i_address_i, pmem_address_o;
    lc3b_cacheline d_wdata_i, d_rdata_o, i_rdata_o, pmem_wdata_o, pmem_rdata_i;
    logic          pmem_read_o, pmem_write_o, pmem_resp_i;

    integer        seed = 32'h9913_9bde;
    int            mismatches = 0;
    int            failures = 0;
    int            checks = 0;
    lc3b_cacheline pmem [4096];                 // Physical memory, one entry per line.
    lc3b_cacheline shadow [lc3b_word];          // Last line written by the data port.

    mem_hierarchy dut (.*);

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Every word of a line holds the line's byte address plus the word number.
    function automatic lc3b_cacheline init_pattern(lc3b_word addr);
        lc3b_cacheline line;
        for (int w = 0; w < 8; w++) begin
            line[w*16 +: 16] = {addr[15:4], 4'h0} + 16'(w);
        end
        return line;
    endfunction

    function automatic lc3b_cacheline expected_line(lc3b_word addr);
        if (shadow.exists({addr[15:4], 4'h0})) begin
            return shadow[{addr[15:4], 4'h0}];
        end
        return init_pattern(addr);
    endfunction

    function automatic lc3b_word pool_addr(int k);
        return 16'h2000 + 16'(k / 2 * 128) + 16'(k % 2 * 16);  // Sixteen tags on two indexes.
    endfunction

    function automatic lc3b_cacheline random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic abort_run(string why);
        failures++;
        $display("%s at %0t", why, $time);
        $display("Errors: %0d mismatches, %0d other failures, %0d lines checked",
                 mismatches, failures, checks);
        $display("Checks failed");
        $finish;
    endtask

    task automatic check_line(string name, lc3b_cacheline got, lc3b_cacheline exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_low(string name, logic got);
        assert (got === 1'b0) else begin
            $display("Mismatch at %0t: %s got %b expected 0", $time, name, got);
            mismatches++;
        end
    endtask

    task automatic check_quiet();
        check_low("d_resp_o", d_resp_o);
        check_low("i_resp_o", i_resp_o);
        check_low("pmem_read_o", pmem_read_o);
        check_low("pmem_write_o", pmem_write_o);
    endtask

    task automatic wait_for_resp(bit data_port, string port);
        bit got;
        int n;
        got = 1'b0;
        n = 0;
        while (!got && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            got = data_port ? d_resp_o : i_resp_o;
            n++;
        end
        if (!got) begin
            abort_run($sformatf("No resp on the %s port within %0d cycles", port, TIMEOUT_CYCLES));
        end
    endtask

    task automatic data_access(logic wr, lc3b_word addr, lc3b_cacheline wd);
        @(posedge clk);
        #1;
        d_read_i    = ~wr;
        d_write_i   = wr;
        d_address_i = addr;
        d_wdata_i   = wd;
        wait_for_resp(1'b1, "data");
        #1;
        d_read_i  = 1'b0;
        d_write_i = 1'b0;
    endtask

    task automatic fetch(lc3b_word addr);
        @(posedge clk);
        #1;
        i_read_i    = 1'b1;
        i_address_i = addr;
        wait_for_resp(1'b0, "instruction");
        #1;
        i_read_i = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory model. Answers each request after one to four cycles.
    initial begin
        int delay;
        pmem_resp_i  = 1'b0;
        pmem_rdata_i = '0;
        for (int i = 0; i < 4096; i++) begin
            pmem[i] = init_pattern(16'(i * 16));
        end
        forever begin
            @(posedge clk);
            if (rst_n_i && (pmem_read_o || pmem_write_o)) begin
                delay = 1 + rand_below(4);
                repeat (delay - 1) @(posedge clk);
                #1;
                if (pmem_write_o) begin
                    pmem[pmem_address_o[15:4]] = pmem_wdata_o;
                end else begin
                    pmem_rdata_i = pmem[pmem_address_o[15:4]];
                end
                pmem_resp_i = 1'b1;
                @(posedge clk);
                #1;
                pmem_resp_i = 1'b0;
            end
        end
    end

    // Compare process. A write resp updates the shadow, a read resp is checked.
    always @(posedge clk) begin
        if (rst_n_i && d_resp_o) begin
            if (d_write_i) begin
                shadow[{d_address_i[15:4], 4'h0}] = d_wdata_i;
            end else begin
                check_line("d_rdata_o", d_rdata_o, expected_line(d_address_i));
            end
        end
        if (rst_n_i && i_resp_o) begin
            check_line("i_rdata_o", i_rdata_o, expected_line(i_address_i));
        end
    end

    initial begin
        lc3b_word      a;
        lc3b_word      b;
        lc3b_cacheline line;
        bit            wr;
        rst_n_i     = 1'b0;
        d_read_i    = 1'b0;
        d_write_i   = 1'b0;
        d_address_i = '0;
        d_wdata_i   = '0;
        i_read_i    = 1'b0;
        i_address_i = '0;
        @(posedge clk);
        repeat (4) begin
            @(posedge clk);
            check_quiet();
        end
        #1;
        rst_n_i = 1'b1;
        @(posedge clk);
        check_quiet();

        fetch(16'h4000);                          // Cold reads of untouched lines.
        fetch(16'h7ff0);
        data_access(1'b1, 16'h1000, random_line());
        data_access(1'b0, 16'h1000, '0);

        // Same index 2, tags 2 and 3, so the second write evicts the first.
        a = 16'h0120;
        b = 16'h01a0;
        data_access(1'b1, a, random_line());
        data_access(1'b1, b, random_line());
        data_access(1'b0, a, '0);
        data_access(1'b0, b, '0);

        repeat (50) begin
            a    = pool_addr(rand_below(32));
            b    = pool_addr(rand_below(32));
            wr   = rand_below(2) == 1;
            line = random_line();
            fork                                  // Both ports raise a request on one edge.
                data_access(wr, a, line);
                fetch(b);
            join
        end

        repeat (300) begin
            a = pool_addr(rand_below(32));
            if (rand_below(3) == 0) begin
                fetch(a);
            end else begin
                wr = rand_below(2) == 1;
                data_access(wr, a, random_line());
            end
        end
        foreach (shadow[key]) begin
            data_access(1'b0, key, '0);
        end

        failures += dut.u_asserts.fail_count;      // Handshake rules broken during the run.
        $display("Errors: %0d mismatches, %0d other failures, %0d lines checked",
                 mismatches, failures, checks);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_mem_hierarchy

//--- tb.f
lc3b_types.sv
mem_if.sv
mem_arbiter.sv
l2_cache.sv
victim_buffer.sv
mem_hierarchy.sv
mem_hierarchy_asserts.sv
tb_mem_hierarchy.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_hierarchy
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
